//--- rtl/cdl_pkg.sv
/*
 * CD data loader shared definitions
 * Widths of the host word and CD byte, the download header layout,
 * the Wishbone classic request/response bundles used on the internal
 * links, and the FSM state encodings of the parser and the feeder.
 */
package cdl_pkg;

	// ============================================================
	// Widths
	// ============================================================
	localparam int WORD_W = 16;
	localparam int BYTE_W = 8;
	localparam int LEN_W  = 15;

	// First word of a download, data-mode flag on top
	typedef struct packed {
		logic             dm;
		logic [LEN_W-1:0] len;
	} cd_header_t;

	// ============================================================
	// Wishbone classic bundles
	// ============================================================
	typedef struct packed {
		logic              cyc;
		logic              stb;
		logic              we;
		logic [WORD_W-1:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic              ack;
		logic [WORD_W-1:0] dat;
	} wb_rsp_t;

	// ============================================================
	// FSM states
	// ============================================================
	typedef enum logic [1:0] {
		PS_HEADER,
		PS_DATA,
		PS_WAIT_ACK,
		PS_DONE
	} parser_state_e;

	typedef enum logic [1:0] {
		FD_IDLE,
		FD_FETCH,
		FD_LOW,
		FD_HIGH
	} feeder_state_e;

endpackage

//--- rtl/cd_stream_parser.sv
`timescale 1ns/1ps
/*
 * CD download stream parser
 * Watches the host download, takes the first word as the header
 * (data-mode flag and word count) and writes up to that many data
 * words into the word FIFO over Wishbone classic. The host is held
 * off with dl_wait until each write is acknowledged.
 */
module cd_stream_parser import cdl_pkg::*; (
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              dl_active,
	input  logic              dl_wr,
	input  logic [WORD_W-1:0] dl_data,
	output logic              dl_wait,
	output logic              cd_dm,
	output logic              flush,
	output wb_req_t           wr_req,
	input  wb_rsp_t           wr_rsp
);

	parser_state_e     state;
	logic              dl_active_q;
	logic              start;
	logic              host_wr;
	cd_header_t        hdr;
	logic [LEN_W-1:0]  len;
	logic [LEN_W-1:0]  cnt;
	logic              wr_cyc;
	logic [WORD_W-1:0] wr_dat;

	assign start   = dl_active & ~dl_active_q;
	assign host_wr = dl_wr & dl_active;
	assign hdr     = cd_header_t'(dl_data);

	// Write cycle holds cyc, stb and we together
	assign wr_req = '{cyc: wr_cyc, stb: wr_cyc, we: wr_cyc, dat: wr_dat};

	// Download start edge and the flush pulse that follows it
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_active_q <= 1'b0;
			flush       <= 1'b0;
		end else begin
			dl_active_q <= dl_active;
			flush       <= start;
		end
	end

	// ============================================================
	// Header / data FSM
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state   <= PS_HEADER;
			len     <= '0;
			cnt     <= '0;
			dl_wait <= 1'b0;
			cd_dm   <= 1'b0;
			wr_cyc  <= 1'b0;
		end else if (start) begin
			// New download abandons whatever was in progress
			state   <= PS_HEADER;
			len     <= '0;
			cnt     <= '0;
			dl_wait <= 1'b0;
			wr_cyc  <= 1'b0;
		end else begin
			case (state)
				PS_HEADER: begin
					if (host_wr) begin
						cd_dm <= hdr.dm;
						len   <= hdr.len;
						cnt   <= '0;
						state <= PS_DATA;
					end
				end
				PS_DATA: begin
					if (host_wr) begin
						dl_wait <= 1'b1;
						if (cnt < len) begin
							wr_cyc <= 1'b1;
							cnt    <= cnt + 1'b1;
							state  <= PS_WAIT_ACK;
						end else begin
							// Length already reached, word is dropped
							state <= PS_DONE;
						end
					end
				end
				PS_WAIT_ACK: begin
					if (wr_rsp.ack) begin
						wr_cyc  <= 1'b0;
						dl_wait <= 1'b0;
						state   <= (cnt == len) ? PS_DONE : PS_DATA;
					end
				end
				PS_DONE: begin
					// Surplus words only get a one-cycle wait pulse
					dl_wait <= host_wr;
				end
				default: state <= PS_HEADER;
			endcase
		end
	end

	// Word held stable on dat for the whole write cycle
	always_ff @(posedge clk_sys) begin
		if (state == PS_DATA && host_wr && cnt < len)
			wr_dat <= dl_data;
	end

	a_no_wr_while_wait: assert property (@(posedge clk_sys) disable iff (reset)
		dl_wait |-> !dl_wr)
		else $error("Host wrote a word while dl_wait was high");

endmodule

//--- rtl/cd_word_fifo.sv
`timescale 1ns/1ps
/*
 * CD word FIFO
 * Circular store of host words between the stream parser and the
 * byte feeder. Two Wishbone classic slave ports, one for writes and
 * one for reads, each with a registered single-cycle ack. A flush
 * pulse empties the store.
 */
module cd_word_fifo import cdl_pkg::*; #(
	parameter int FIFO_DEPTH = 8
) (
	input  logic    clk_sys,
	input  logic    reset,
	input  logic    flush,
	input  wb_req_t wr_req,
	output wb_rsp_t wr_rsp,
	input  wb_req_t rd_req,
	output wb_rsp_t rd_rsp
);

	localparam int AW = $clog2(FIFO_DEPTH);

	if (FIFO_DEPTH < 2 || (FIFO_DEPTH & (FIFO_DEPTH - 1)) != 0) begin : g_depth_check
		$error("FIFO_DEPTH must be a power of two of at least 2");
	end

	logic [WORD_W-1:0] mem [FIFO_DEPTH];
	logic [AW-1:0]     wr_ptr;
	logic [AW-1:0]     rd_ptr;
	logic [AW:0]       count;
	logic              full;
	logic              empty;
	logic              wr_acc;
	logic              rd_acc;
	logic              wr_ack;
	logic              rd_ack;
	logic [WORD_W-1:0] rd_dat;

	assign full  = (count == (AW+1)'(FIFO_DEPTH));
	assign empty = (count == '0);

	// No second accept in the cycle the master sees its ack
	assign wr_acc = wr_req.cyc & wr_req.stb & wr_req.we & ~wr_ack & ~full;
	assign rd_acc = rd_req.cyc & rd_req.stb & ~rd_req.we & ~rd_ack & ~empty;

	assign wr_rsp = '{ack: wr_ack, dat: {WORD_W{1'b0}}};
	assign rd_rsp = '{ack: rd_ack, dat: rd_dat};

	// ============================================================
	// Pointers, fill count and acks
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (reset || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			wr_ack <= 1'b0;
			rd_ack <= 1'b0;
		end else begin
			wr_ack <= wr_acc;
			rd_ack <= rd_acc;
			if (wr_acc)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_acc)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr_acc, rd_acc})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Storage and read data
	always_ff @(posedge clk_sys) begin
		if (wr_acc)
			mem[wr_ptr] <= wr_req.dat;
		if (rd_acc)
			rd_dat <= mem[rd_ptr];
	end

	a_no_ack_full: assert property (@(posedge clk_sys) disable iff (reset || flush)
		wr_ack |-> $past(count) < FIFO_DEPTH)
		else $error("Write acked while the FIFO was full");

	a_no_ack_empty: assert property (@(posedge clk_sys) disable iff (reset || flush)
		rd_ack |-> $past(count) != 0)
		else $error("Read acked while the FIFO was empty");

endmodule

//--- rtl/cd_byte_feeder.sv
`timescale 1ns/1ps
/*
 * CD byte feeder
 * Reads words from the word FIFO over Wishbone classic and hands them
 * to the CD engine one byte at a time, low byte first. Each byte gets
 * a single-cycle cd_wr while cd_ready is high, followed by an idle
 * cycle before the next strobe.
 */
module cd_byte_feeder import cdl_pkg::*; (
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              flush,
	output wb_req_t           rd_req,
	input  wb_rsp_t           rd_rsp,
	input  logic              cd_ready,
	output logic [BYTE_W-1:0] cd_data,
	output logic              cd_wr
);

	feeder_state_e     state;
	logic              rd_cyc;
	logic [WORD_W-1:0] word;

	// Read cycle, we stays low
	assign rd_req = '{cyc: rd_cyc, stb: rd_cyc, we: 1'b0, dat: {WORD_W{1'b0}}};

	// Byte select follows the FSM
	assign cd_data = (state == FD_HIGH) ? word[WORD_W-1:BYTE_W] : word[BYTE_W-1:0];

	// ============================================================
	// Fetch and serialize FSM
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (reset || flush) begin
			state  <= FD_IDLE;
			rd_cyc <= 1'b0;
			cd_wr  <= 1'b0;
		end else begin
			case (state)
				FD_IDLE: begin
					rd_cyc <= 1'b1;
					state  <= FD_FETCH;
				end
				FD_FETCH: begin
					if (rd_rsp.ack) begin
						rd_cyc <= 1'b0;
						state  <= FD_LOW;
					end
				end
				FD_LOW: begin
					if (cd_wr) begin
						cd_wr <= 1'b0;
						state <= FD_HIGH;
					end else if (cd_ready) begin
						cd_wr <= 1'b1;
					end
				end
				FD_HIGH: begin
					if (cd_wr) begin
						// Word done, go straight for the next one
						cd_wr  <= 1'b0;
						rd_cyc <= 1'b1;
						state  <= FD_FETCH;
					end else if (cd_ready) begin
						cd_wr <= 1'b1;
					end
				end
				default: state <= FD_IDLE;
			endcase
		end
	end

	// Word captured on the read ack
	always_ff @(posedge clk_sys) begin
		if (state == FD_FETCH && rd_rsp.ack)
			word <= rd_rsp.dat;
	end

	a_single_strobe: assert property (@(posedge clk_sys) disable iff (reset)
		cd_wr |=> !cd_wr)
		else $error("cd_wr held high for two cycles");

endmodule

//--- rtl/pce_cd_loader.sv
`timescale 1ns/1ps
/*
 * PC Engine CD data loader
 * Host word stream in, CD engine byte strobes out.
 * Parser, word FIFO and byte feeder joined by two Wishbone links.
 */
module pce_cd_loader import cdl_pkg::*; #(
	parameter int FIFO_DEPTH = 8
) (
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              dl_active,
	input  logic              dl_wr,
	input  logic [WORD_W-1:0] dl_data,
	output logic              dl_wait,
	input  logic              cd_ready,
	output logic [BYTE_W-1:0] cd_data,
	output logic              cd_wr,
	output logic              cd_dm
);

	logic    flush;
	wb_req_t wr_req;
	wb_rsp_t wr_rsp;
	wb_req_t rd_req;
	wb_rsp_t rd_rsp;

	// ============================================================
	// Host side
	// ============================================================
	cd_stream_parser u_parser (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.dl_active (dl_active),
		.dl_wr     (dl_wr),
		.dl_data   (dl_data),
		.dl_wait   (dl_wait),
		.cd_dm     (cd_dm),
		.flush     (flush),
		.wr_req    (wr_req),
		.wr_rsp    (wr_rsp)
	);

	cd_word_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_fifo (
		.clk_sys (clk_sys),
		.reset   (reset),
		.flush   (flush),
		.wr_req  (wr_req),
		.wr_rsp  (wr_rsp),
		.rd_req  (rd_req),
		.rd_rsp  (rd_rsp)
	);

	// ============================================================
	// CD engine side
	// ============================================================
	cd_byte_feeder u_feeder (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.flush    (flush),
		.rd_req   (rd_req),
		.rd_rsp   (rd_rsp),
		.cd_ready (cd_ready),
		.cd_data  (cd_data),
		.cd_wr    (cd_wr)
	);

endmodule

//--- include/tb_cd_checks.svh
/*
 * CD data loader testbench checks
 * Error and per-test counters, and the concurrent assertions that
 * compare the DUT outputs with the host stimulus and with the head
 * of the expected byte queue.
 */
`ifndef TB_CD_CHECKS_SVH
`define TB_CD_CHECKS_SVH

int test_errs    = 0;
int err_total    = 0;
int tests_passed = 0;
int tests_failed = 0;

task automatic record_error(input string msg);
	$display("ERROR %0t: %s", $time, msg);
	test_errs++;
	err_total++;
endtask

task automatic finish_test(input string name);
	if (test_errs == 0) begin
		tests_passed++;
		$display("Test %s: passed", name);
	end else begin
		tests_failed++;
		$display("Test %s: failed with %0d errors", name, test_errs);
	end
	test_errs = 0;
endtask

// ============================================================
// Host side
// ============================================================
a_idle_before_header: assert property (@(posedge clk_sys) disable iff (reset)
	!hdr_seen |-> !cd_wr && !dl_wait && !cd_dm)
	else record_error("output active before the first header write");

a_dm_from_header: assert property (@(posedge clk_sys) disable iff (reset)
	dm_valid |-> cd_dm == exp_dm)
	else record_error($sformatf("cd_dm %0b, expected %0b", $sampled(cd_dm), $sampled(exp_dm)));

a_host_respects_wait: assert property (@(posedge clk_sys) disable iff (reset)
	dl_wait |-> !dl_wr)
	else record_error("host wrote a word while dl_wait was high");

// Surplus word gets exactly one wait cycle
a_surplus_wait_pulse: assert property (@(posedge clk_sys) disable iff (reset)
	in_surplus && dl_wait |=> !dl_wait)
	else record_error("dl_wait held longer than one cycle for a surplus word");

// ============================================================
// CD engine side
// ============================================================
a_byte_expected: assert property (@(posedge clk_sys) disable iff (reset)
	cd_wr |-> head_valid)
	else record_error($sformatf("cd_wr with byte %h, none expected", $sampled(cd_data)));

a_byte_value: assert property (@(posedge clk_sys) disable iff (reset)
	cd_wr && head_valid |-> cd_data == head_byte)
	else record_error($sformatf("cd_data %h, expected %h",
		$sampled(cd_data), $sampled(head_byte)));

a_strobe_on_ready: assert property (@(posedge clk_sys) disable iff (reset)
	cd_wr |-> $past(cd_ready))
	else record_error("cd_wr raised while cd_ready was low");

a_quiet_on_restart: assert property (@(posedge clk_sys) disable iff (reset)
	restart_window |-> !cd_wr)
	else record_error("cd_wr during download restart");

`endif

//--- tb/tb_pce_cd_loader.sv
`timescale 1ns/1ps
/*
 * CD data loader testbench
 * Streams host downloads into the loader, keeps the expected CD bytes
 * in a queue and lets the included assertions check every strobe.
 * Covers reset state, data mode, byte order, length limit, CD engine
 * back-pressure and a download restart.
 */
module tb_pce_cd_loader import cdl_pkg::*; ();

	localparam int FIFO_DEPTH = 8;
	localparam int CLK_PERIOD = 8;
	// Headers plus data words over all tests
	localparam int WORDS_SENT = 5 + 11 + 10 + 21 + 14;

	logic              clk_sys = 1'b0;
	logic              reset;
	logic              dl_active;
	logic              dl_wr;
	logic [WORD_W-1:0] dl_data;
	logic              dl_wait;
	logic              cd_ready;
	logic [BYTE_W-1:0] cd_data;
	logic              cd_wr;
	logic              cd_dm;

	// Scoreboard and check flags
	logic [BYTE_W-1:0] exp_q [$];
	logic              head_valid = 1'b0;
	logic [BYTE_W-1:0] head_byte = '0;
	logic              hdr_seen;
	logic              dm_valid;
	logic              exp_dm;
	logic              in_surplus;
	logic              restart_window;
	integer            seed = 32'h4d33e63f;
	int                ready_hold;
	logic              ready_rand;
	logic [LEN_W-1:0]  cur_len;
	int                word_idx;

	`include "tb_cd_checks.svh"

	pce_cd_loader #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_dut (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.dl_active (dl_active),
		.dl_wr     (dl_wr),
		.dl_data   (dl_data),
		.dl_wait   (dl_wait),
		.cd_ready  (cd_ready),
		.cd_data   (cd_data),
		.cd_wr     (cd_wr),
		.cd_dm     (cd_dm)
	);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	// Queue head for the byte checks, stable across the next edge
	always @(negedge clk_sys) begin
		head_valid = (exp_q.size() != 0);
		head_byte  = head_valid ? exp_q[0] : '0;
	end

	always @(posedge clk_sys) begin
		if (!reset && cd_wr && exp_q.size() != 0)
			void'(exp_q.pop_front());
	end

	// ============================================================
	// Stimulus tasks
	// ============================================================
	task automatic tick();
		logic [31:0] r;
		@(posedge clk_sys);
		#1;
		if (ready_hold > 0) begin
			ready_hold--;
			cd_ready = 1'b0;
		end else if (ready_rand) begin
			r = $random(seed);
			cd_ready = (r[1:0] != 2'b00);
		end else begin
			cd_ready = 1'b1;
		end
	endtask

	task automatic pause_ready(input int cycles);
		ready_hold = cycles;
		cd_ready   = 1'b0;
	endtask

	task automatic start_download(input logic dm, input logic [LEN_W-1:0] len);
		cd_header_t hdr;
		hdr = '{dm: dm, len: len};
		dl_active = 1'b0;
		tick();
		dl_active = 1'b1;
		// Let the flush go through before the header
		tick();
		tick();
		hdr_seen = 1'b1;
		dm_valid = 1'b0;
		dl_data  = hdr;
		dl_wr    = 1'b1;
		tick();
		dl_wr    = 1'b0;
		exp_dm   = dm;
		dm_valid = 1'b1;
		cur_len  = len;
		word_idx = 0;
	endtask

	task automatic host_word();
		logic [WORD_W-1:0] w;
		w = WORD_W'($random(seed));
		in_surplus = (word_idx >= cur_len);
		if (!in_surplus) begin
			exp_q.push_back(w[BYTE_W-1:0]);
			exp_q.push_back(w[WORD_W-1:BYTE_W]);
		end
		restart_window = 1'b0;
		dl_data = w;
		dl_wr   = 1'b1;
		tick();
		dl_wr = 1'b0;
		while (dl_wait)
			tick();
		in_surplus = 1'b0;
		word_idx++;
	endtask

	task automatic send_words(input int n);
		repeat (n)
			host_word();
	endtask

	task automatic drain_and_check();
		for (int i = 0; i < 2000 && exp_q.size() != 0; i++)
			tick();
		// A few more cycles to catch stray strobes
		repeat (20)
			tick();
		assert (exp_q.size() == 0) else begin
			$display("Bytes missing at %0t: %0d expected bytes never reached the CD engine",
				$time, exp_q.size());
			test_errs++;
			err_total++;
		end
	endtask

	// ============================================================
	// Watchdog
	// ============================================================
	initial begin
		#(WORDS_SENT * 200 * CLK_PERIOD);
		$display("Run timed out: the tests did not finish within %0d cycles", WORDS_SENT * 200);
		$display("=== FAIL ===");
		$finish;
	end

	// ============================================================
	// Test sequence
	// ============================================================
	initial begin
		reset          = 1'b1;
		dl_active      = 1'b0;
		dl_wr          = 1'b0;
		dl_data        = '0;
		cd_ready       = 1'b0;
		hdr_seen       = 1'b0;
		dm_valid       = 1'b0;
		exp_dm         = 1'b0;
		in_surplus     = 1'b0;
		restart_window = 1'b0;
		ready_hold     = 0;
		ready_rand     = 1'b0;
		cur_len        = '0;
		word_idx       = 0;
		tick();
		tick();
		reset = 1'b0;

		repeat (10)
			tick();
		finish_test("reset_idle");

		start_download(1'b1, 15'd4);
		send_words(4);
		drain_and_check();
		finish_test("header_dm");

		start_download(1'b0, 15'd10);
		send_words(10);
		drain_and_check();
		finish_test("byte_order");

		start_download(1'b1, 15'd5);
		send_words(9);
		drain_and_check();
		finish_test("length_limit");

		// Long stall fills the FIFO, then random ready
		ready_rand = 1'b1;
		start_download(1'b0, 15'd20);
		pause_ready(150);
		send_words(20);
		drain_and_check();
		ready_rand = 1'b0;
		finish_test("ready_backpressure");

		start_download(1'b1, 15'd12);
		send_words(6);
		// Engine stalled up to the flush, ready again while old words remain
		pause_ready(3);
		tick();
		tick();
		exp_q.delete();
		restart_window = 1'b1;
		start_download(1'b0, 15'd6);
		send_words(6);
		drain_and_check();
		finish_test("restart");

		$display("Tests passed: %0d, failed: %0d, errors: %0d",
			tests_passed, tests_failed, err_total);
		if (tests_failed == 0 && err_total == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

//--- pce_cd_loader.f
+incdir+include
rtl/cdl_pkg.sv
rtl/cd_stream_parser.sv
rtl/cd_word_fifo.sv
rtl/cd_byte_feeder.sv
rtl/pce_cd_loader.sv
tb/tb_pce_cd_loader.sv

//--- Bender.yml
package:
  name: pce_cd_loader

sources:
  - files:
      - rtl/cdl_pkg.sv
      - rtl/cd_stream_parser.sv
      - rtl/cd_word_fifo.sv
      - rtl/cd_byte_feeder.sv
      - rtl/pce_cd_loader.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/tb_pce_cd_loader.sv
